//--- design/cpu_pkg.sv
package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t RESET_PC = '0;
    localparam word_t NOP_INST = 32'h0000_0033;  // add x0, x0, x0

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {WB_ALU, WB_PC4, WB_MEM, WB_IMM} wb_sel_e;

    typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word, six views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

    typedef struct packed {
        logic       rf_we;
        wb_sel_e    wb_sel;
        alu_op_e    alu_op;
        logic       src1_pc;   // Operand a is the PC
        logic       src2_imm;  // Operand b is the immediate
        logic       dm_we;
        logic       is_load;
        logic       branch;
        logic       jal;
        logic       jalr;
        logic [2:0] br_funct;
        logic       rs1_used;
        logic       rs2_used;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t pc4;
        inst_u inst;
    } if_id_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc;
        word_t     pc4;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     rd0;
        word_t     rd1;
        word_t     imm;
    } id_ex_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc4;
        reg_addr_t rd;
        word_t     alu_res;
        word_t     store_data;
        word_t     imm;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc4;
        reg_addr_t rd;
        word_t     alu_res;
        word_t     load_data;
        word_t     imm;
    } mem_wb_t;

endpackage

//--- design/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder (
    input  cpu_pkg::inst_u inst,
    output cpu_pkg::ctrl_t ctrl,
    output cpu_pkg::word_t imm
);
    import cpu_pkg::*;

    // alt picks sub over add and sra over srl
    function automatic alu_op_e alu_from_f3(logic [2:0] f3, logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl = '0;  // Unknown opcodes stay a bubble
        case (inst.r.opcode)
            OP_LUI: begin
                ctrl.rf_we  = 1'b1;
                ctrl.wb_sel = WB_IMM;
            end
            OP_AUIPC: begin
                ctrl.rf_we    = 1'b1;
                ctrl.src1_pc  = 1'b1;
                ctrl.src2_imm = 1'b1;
            end
            OP_JAL: begin
                ctrl.rf_we    = 1'b1;
                ctrl.wb_sel   = WB_PC4;
                ctrl.src1_pc  = 1'b1;
                ctrl.src2_imm = 1'b1;
                ctrl.jal      = 1'b1;
            end
            OP_JALR: begin
                ctrl.rf_we    = 1'b1;
                ctrl.wb_sel   = WB_PC4;
                ctrl.src2_imm = 1'b1;
                ctrl.jalr     = 1'b1;
                ctrl.rs1_used = 1'b1;
            end
            OP_BRANCH: begin
                if (inst.b.funct3[2:1] != 2'b01) begin
                    ctrl.branch   = 1'b1;
                    ctrl.br_funct = inst.b.funct3;
                    ctrl.src1_pc  = 1'b1;  // Target is pc + imm
                    ctrl.src2_imm = 1'b1;
                    ctrl.rs1_used = 1'b1;
                    ctrl.rs2_used = 1'b1;
                end
            end
            OP_LOAD: begin
                if (inst.i.funct3 == 3'b010) begin
                    ctrl.rf_we    = 1'b1;
                    ctrl.wb_sel   = WB_MEM;
                    ctrl.is_load  = 1'b1;
                    ctrl.src2_imm = 1'b1;
                    ctrl.rs1_used = 1'b1;
                end
            end
            OP_STORE: begin
                if (inst.s.funct3 == 3'b010) begin
                    ctrl.dm_we    = 1'b1;
                    ctrl.src2_imm = 1'b1;
                    ctrl.rs1_used = 1'b1;
                    ctrl.rs2_used = 1'b1;
                end
            end
            OP_IMM: begin
                ctrl.rf_we    = 1'b1;
                ctrl.alu_op   = alu_from_f3(inst.i.funct3,
                                            inst.i.funct3 == 3'b101 && inst.r.funct7[5]);
                ctrl.src2_imm = 1'b1;
                ctrl.rs1_used = 1'b1;
            end
            OP_REG: begin
                ctrl.rf_we    = 1'b1;
                ctrl.alu_op   = alu_from_f3(inst.r.funct3, inst.r.funct7[5]);
                ctrl.rs1_used = 1'b1;
                ctrl.rs2_used = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (inst.r.opcode)
            OP_STORE:
                imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
            OP_BRANCH:
                imm = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                       inst.b.imm10_5, inst.b.imm4_1, 1'b0};
            OP_LUI, OP_AUIPC:
                imm = {inst.u.imm, 12'b0};
            OP_JAL:
                imm = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                       inst.j.imm11, inst.j.imm10_1, 1'b0};
            default:
                imm = {{20{inst.i.imm[11]}}, inst.i.imm};  // I-type
        endcase
    end

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::reg_addr_t ra0,
    input  cpu_pkg::reg_addr_t ra1,
    output cpu_pkg::word_t     rd0,
    output cpu_pkg::word_t     rd1,
    input  cpu_pkg::reg_addr_t wa,
    input  logic               we,
    input  cpu_pkg::word_t     wd
);
    import cpu_pkg::*;

    word_t regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin  // x0 never written
            regs[wa] <= wd;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign rd0 = (we && wa != '0 && wa == ra0) ? wd : regs[ra0];
    assign rd1 = (we && wa != '0 && wa == ra1) ? wd : regs[ra1];

    x0_reads_zero: assert property (@(posedge clk) disable iff (reset)
        ra0 == '0 |-> rd0 == '0);

endmodule

//--- design/alu.sv
`timescale 1ns/1ns

module alu (
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::alu_op_e op,
    output cpu_pkg::word_t   y
);
    import cpu_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_SLL:  y = a << shamt;
            ALU_SLT:  y = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: y = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:  y = a ^ b;
            ALU_SRL:  y = a >> shamt;
            ALU_SRA:  y = $signed(a) >>> shamt;  // Sign fill
            ALU_OR:   y = a | b;
            ALU_AND:  y = a & b;
            default:  y = '0;
        endcase
    end

endmodule

//--- design/branch_unit.sv
`timescale 1ns/1ns

module branch_unit (
    input  cpu_pkg::ctrl_t ctrl,
    input  cpu_pkg::word_t rs1_val,
    input  cpu_pkg::word_t rs2_val,
    input  cpu_pkg::word_t alu_res,
    output logic           redirect,
    output cpu_pkg::word_t target
);
    import cpu_pkg::*;

    logic taken;

    always_comb begin
        case (ctrl.br_funct)
            F3_BEQ:  taken = rs1_val == rs2_val;
            F3_BNE:  taken = rs1_val != rs2_val;
            F3_BLT:  taken = $signed(rs1_val) < $signed(rs2_val);
            F3_BGE:  taken = $signed(rs1_val) >= $signed(rs2_val);
            F3_BLTU: taken = rs1_val < rs2_val;
            F3_BGEU: taken = rs1_val >= rs2_val;
            default: taken = 1'b0;
        endcase
    end

    assign redirect = (ctrl.branch && taken) || ctrl.jal || ctrl.jalr;
    assign target   = ctrl.jalr ? {alu_res[XLEN-1:1], 1'b0} : alu_res;  // jalr clears bit 0

    // Immediates and the link register must keep fetch word aligned
    always_comb begin
        if (redirect) begin
            target_aligned: assert final (target[1:0] == 2'b00)
                else $error("misaligned redirect target %h", target);
        end
    end

endmodule

//--- design/hazard_ctrl.sv
`timescale 1ns/1ns

module hazard_ctrl (
    input  cpu_pkg::id_ex_t    id_ex,
    input  cpu_pkg::reg_addr_t if_id_rs1,
    input  cpu_pkg::reg_addr_t if_id_rs2,
    input  cpu_pkg::ctrl_t     id_uses,
    input  cpu_pkg::ex_mem_t   ex_mem,
    input  cpu_pkg::mem_wb_t   mem_wb,
    input  logic               redirect,
    output cpu_pkg::fwd_sel_e  fwd_a,
    output cpu_pkg::fwd_sel_e  fwd_b,
    output logic               stall,
    output logic               flush
);
    import cpu_pkg::*;

    logic use_rs1, use_rs2;

    // Youngest producer wins
    function automatic fwd_sel_e fwd_source(reg_addr_t rs, logic used,
                                            ex_mem_t em, mem_wb_t mw);
        fwd_sel_e sel;
        sel = FWD_NONE;
        if (used && rs != '0) begin
            if (em.ctrl.rf_we && em.rd == rs) begin
                sel = FWD_MEM;
            end else if (mw.ctrl.rf_we && mw.rd == rs) begin
                sel = FWD_WB;
            end
        end
        return sel;
    endfunction

    assign fwd_a = fwd_source(id_ex.rs1, id_ex.ctrl.rs1_used, ex_mem, mem_wb);
    assign fwd_b = fwd_source(id_ex.rs2, id_ex.ctrl.rs2_used, ex_mem, mem_wb);

    // Load in EX feeding the instruction in decode
    assign use_rs1 = id_uses.rs1_used && id_ex.rd == if_id_rs1;
    assign use_rs2 = id_uses.rs2_used && id_ex.rd == if_id_rs2;
    assign stall   = id_ex.ctrl.is_load && id_ex.rd != '0 && (use_rs1 || use_rs2);
    assign flush   = redirect;

    // A load never redirects, so the two cannot meet
    always_comb begin
        if (stall) begin
            stall_flush_excl: assert final (!flush)
                else $error("stall and flush raised together");
        end
    end

endmodule

//--- design/cpu_top.sv
`timescale 1ns/1ns

module cpu_top (
    input  logic           clk,
    input  logic           reset,
    output cpu_pkg::word_t im_addr,
    input  cpu_pkg::word_t im_dout,
    output cpu_pkg::word_t mem_addr,
    output logic           mem_we,
    output cpu_pkg::word_t mem_din,
    input  cpu_pkg::word_t mem_dout
);
    import cpu_pkg::*;

    word_t    pc, pc4, next_pc;
    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;
    ctrl_t    id_ctrl;
    word_t    id_imm, rf_rd0, rf_rd1;
    fwd_sel_e fwd_a, fwd_b;
    logic     stall, flush, redirect;
    word_t    br_target;
    word_t    mem_fwd, wb_data, rs1_val, rs2_val;
    word_t    alu_a, alu_b, alu_res;

    function automatic word_t fwd_pick(fwd_sel_e sel, word_t rf_val, word_t mem_val,
                                       word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    assign pc4     = pc + 32'd4;
    assign next_pc = redirect ? br_target : pc4;
    assign im_addr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (!stall) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            if_id.inst <= NOP_INST;
        end else if (!stall) begin
            if_id <= '{pc: pc, pc4: pc4, inst: im_dout};
        end
    end

    inst_decoder u_dec (
        .inst (if_id.inst),
        .ctrl (id_ctrl),
        .imm  (id_imm)
    );

    reg_file u_rf (
        .clk   (clk),
        .reset (reset),
        .ra0   (if_id.inst.r.rs1),
        .ra1   (if_id.inst.r.rs2),
        .rd0   (rf_rd0),
        .rd1   (rf_rd1),
        .wa    (mem_wb.rd),
        .we    (mem_wb.ctrl.rf_we),
        .wd    (wb_data)
    );

    always_ff @(posedge clk) begin
        if (reset || stall || flush) begin
            id_ex.ctrl <= '0;  // Bubble
        end else begin
            id_ex.ctrl <= id_ctrl;
        end
        id_ex.pc  <= if_id.pc;
        id_ex.pc4 <= if_id.pc4;
        id_ex.rs1 <= if_id.inst.r.rs1;
        id_ex.rs2 <= if_id.inst.r.rs2;
        id_ex.rd  <= if_id.inst.r.rd;
        id_ex.rd0 <= rf_rd0;
        id_ex.rd1 <= rf_rd1;
        id_ex.imm <= id_imm;
    end

    // Value an instruction in MEM would write back
    always_comb begin
        case (ex_mem.ctrl.wb_sel)
            WB_PC4:  mem_fwd = ex_mem.pc4;
            WB_IMM:  mem_fwd = ex_mem.imm;
            default: mem_fwd = ex_mem.alu_res;
        endcase
    end

    assign rs1_val = fwd_pick(fwd_a, id_ex.rd0, mem_fwd, wb_data);
    assign rs2_val = fwd_pick(fwd_b, id_ex.rd1, mem_fwd, wb_data);
    assign alu_a   = id_ex.ctrl.src1_pc ? id_ex.pc : rs1_val;
    assign alu_b   = id_ex.ctrl.src2_imm ? id_ex.imm : rs2_val;

    alu u_alu (
        .a  (alu_a),
        .b  (alu_b),
        .op (id_ex.ctrl.alu_op),
        .y  (alu_res)
    );

    branch_unit u_br (
        .ctrl     (id_ex.ctrl),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .alu_res  (alu_res),
        .redirect (redirect),
        .target   (br_target)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem.ctrl <= '0;
        end else begin
            ex_mem.ctrl <= id_ex.ctrl;
        end
        ex_mem.pc4        <= id_ex.pc4;
        ex_mem.rd         <= id_ex.rd;
        ex_mem.alu_res    <= alu_res;
        ex_mem.store_data <= rs2_val;
        ex_mem.imm        <= id_ex.imm;
    end

    assign mem_addr = ex_mem.alu_res;
    assign mem_din  = ex_mem.store_data;
    assign mem_we   = ex_mem.ctrl.dm_we;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb.ctrl <= '0;
        end else begin
            mem_wb.ctrl <= ex_mem.ctrl;
        end
        mem_wb.pc4       <= ex_mem.pc4;
        mem_wb.rd        <= ex_mem.rd;
        mem_wb.alu_res   <= ex_mem.alu_res;
        mem_wb.load_data <= mem_dout;
        mem_wb.imm       <= ex_mem.imm;
    end

    always_comb begin
        case (mem_wb.ctrl.wb_sel)
            WB_PC4:  wb_data = mem_wb.pc4;
            WB_MEM:  wb_data = mem_wb.load_data;
            WB_IMM:  wb_data = mem_wb.imm;
            default: wb_data = mem_wb.alu_res;
        endcase
    end

    hazard_ctrl u_hzd (
        .id_ex     (id_ex),
        .if_id_rs1 (if_id.inst.r.rs1),
        .if_id_rs2 (if_id.inst.r.rs2),
        .id_uses   (id_ctrl),
        .ex_mem    (ex_mem),
        .mem_wb    (mem_wb),
        .redirect  (redirect),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .stall     (stall),
        .flush     (flush)
    );

endmodule

//--- dv/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb;
    import cpu_pkg::*;

    localparam int N_STORES = 18;
    localparam word_t NOP = 32'h0000_0033;

    logic  clk;
    logic  reset;
    word_t im_addr, im_dout;
    word_t mem_addr, mem_din, mem_dout;
    logic  mem_we;

    word_t prog [128];
    int    prog_len;
    word_t ram [64];
    int    cycles;

    // Expected stores in program order
    word_t exp_addr [N_STORES] = '{
        32'h00, 32'h04, 32'h08, 32'h0c, 32'h10, 32'h14, 32'h18, 32'h1c, 32'h20,
        32'h24, 32'h28, 32'h2c, 32'h30, 32'h34, 32'h38, 32'h3c, 32'h40, 32'h44
    };
    word_t exp_data [N_STORES] = '{
        32'h0000_0002, 32'hffff_fffd, 32'hffff_fffe, 32'h0000_00a0, 32'h0000_000f,
        32'h0000_0001, 32'h0000_0000, 32'hffff_fff8, 32'h0000_0030, 32'h1234_5000,
        32'h0000_1058, 32'h0000_0002, 32'h0000_003f, 32'h0000_0000, 32'h0000_00f4,
        32'h0000_0108, 32'h0000_0000, 32'h0000_0000
    };

    // Branch funct3 with operands for the taken and the not-taken form
    logic [2:0] br_f3   [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    logic [4:0] tk_rs1  [6] = '{5'd1, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};
    logic [4:0] tk_rs2  [6] = '{5'd1, 5'd2, 5'd1, 5'd2, 5'd2, 5'd1};
    logic [4:0] nt_rs1  [6] = '{5'd1, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1};
    logic [4:0] nt_rs2  [6] = '{5'd2, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};

    cpu_top uut (
        .clk      (clk),
        .reset    (reset),
        .im_addr  (im_addr),
        .im_dout  (im_dout),
        .mem_addr (mem_addr),
        .mem_we   (mem_we),
        .mem_din  (mem_din),
        .mem_dout (mem_dout)
    );

    function automatic word_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                    logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                    logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_sw(logic [11:0] imm, logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic word_t enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic put(word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic check_val(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("** Error: %s is %h, expected %h", name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic build_program();
        prog_len = 0;
        put(enc_i(12'd5, 5'd0, 3'b000, 5'd1, 7'h13));          // addi x1,x0,5
        put(enc_i(-12'sd3, 5'd0, 3'b000, 5'd2, 7'h13));        // addi x2,x0,-3
        put(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, 7'h33));    // add x3
        put(enc_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd4, 7'h33));    // sub x4
        put(enc_sw(12'd0, 5'd3));
        put(enc_sw(12'd4, 5'd4));
        put(enc_i(12'h401, 5'd4, 3'b101, 5'd5, 7'h13));        // srai x5,x4,1
        put(enc_r(7'h00, 5'd1, 5'd1, 3'b001, 5'd6, 7'h33));    // sll
        put(enc_i(12'd28, 5'd2, 3'b101, 5'd7, 7'h13));         // srli
        put(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd8, 7'h33));    // slt
        put(enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd9, 7'h33));    // sltu
        put(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd10, 7'h33));   // xor
        put(enc_i(12'h030, 5'd1, 3'b110, 5'd11, 7'h13));       // ori
        put(enc_r(7'h00, 5'd11, 5'd10, 3'b111, 5'd12, 7'h33)); // and
        put(enc_sw(12'd8, 5'd5));
        put(enc_sw(12'd12, 5'd6));
        put(enc_sw(12'd16, 5'd7));
        put(enc_sw(12'd20, 5'd8));
        put(enc_sw(12'd24, 5'd9));
        put(enc_sw(12'd28, 5'd10));
        put(enc_sw(12'd32, 5'd12));
        put({20'h12345, 5'd13, 7'h37});                        // lui
        put({20'h00001, 5'd14, 7'h17});                        // auipc at 0x58
        put(enc_sw(12'd36, 5'd13));
        put(enc_sw(12'd40, 5'd14));
        put(enc_i(12'd4, 5'd0, 3'b010, 5'd15, 7'h03));         // lw x15
        put(enc_r(7'h00, 5'd1, 5'd15, 3'b000, 5'd16, 7'h33));  // Load-use add
        put(enc_sw(12'd44, 5'd16));
        for (int k = 0; k < 6; k++) begin
            put(enc_b(13'd12, tk_rs2[k], tk_rs1[k], br_f3[k]));
            put(enc_i(12'd1, 5'd21, 3'b000, 5'd21, 7'h13));    // Wrong path
            put(enc_i(12'd1, 5'd21, 3'b000, 5'd21, 7'h13));
            put(enc_b(13'd8, nt_rs2[k], nt_rs1[k], br_f3[k]));
            put(enc_i(12'(1 << k), 5'd20, 3'b000, 5'd20, 7'h13));
        end
        put(enc_sw(12'd48, 5'd20));
        put(enc_sw(12'd52, 5'd21));
        put(enc_j(21'd12, 5'd22));                             // jal at 0xf0
        put(enc_i(12'd1, 5'd21, 3'b000, 5'd21, 7'h13));
        put(enc_i(12'd1, 5'd21, 3'b000, 5'd21, 7'h13));
        put(enc_sw(12'd56, 5'd22));
        put({20'h00000, 5'd23, 7'h17});                        // auipc x23 = 0x100
        put(enc_i(12'd21, 5'd23, 3'b000, 5'd24, 7'h67));       // jalr to odd 0x115
        put(enc_i(12'd1, 5'd21, 3'b000, 5'd21, 7'h13));
        put(enc_i(12'd1, 5'd21, 3'b000, 5'd21, 7'h13));
        put(enc_i(12'd1, 5'd21, 3'b000, 5'd21, 7'h13));
        put(enc_sw(12'd60, 5'd24));
        put(enc_sw(12'd64, 5'd21));
        put(enc_i(12'd7, 5'd0, 3'b000, 5'd0, 7'h13));          // addi x0,x0,7
        put(enc_sw(12'd68, 5'd0));
        put(enc_j(21'd0, 5'd0));                               // Jump to self
    endtask

    assign im_dout  = (im_addr[31:2] < prog_len) ? prog[im_addr[31:2]] : NOP;
    assign mem_dout = ram[mem_addr[7:2]];

    always @(posedge clk) begin
        if (mem_we) begin
            ram[mem_addr[7:2]] <= mem_din;
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        reset <= 1'b1;
        build_program();
        for (int i = 0; i < 64; i++) begin
            ram[i] = 32'h5a00_0000 | (i << 2);
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end

    // Fetch address and timeout watch
    always @(negedge clk) begin
        if (reset) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
            if (im_addr[1:0] != 2'b00) begin
                $display("Fetch address %h is not word aligned", im_addr);
                $display("FAIL: see errors above");
                $fatal(1);
            end else if (im_addr >= 4 * prog_len + 8) begin
                $display("Fetch ran past the final jump, address %h", im_addr);
                $display("FAIL: see errors above");
                $fatal(1);
            end else if (cycles > 8 * prog_len + 100) begin
                $display("Timeout: the expected stores did not complete");
                $display("FAIL: see errors above");
                $fatal(1);
            end
        end
    end

    initial begin
        for (int i = 0; i < N_STORES; i++) begin
            @(negedge clk);
            while (reset || !mem_we) @(negedge clk);
            check_val("mem_addr", mem_addr, exp_addr[i]);
            check_val("mem_din", mem_din, exp_data[i]);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- tb.f
design/cpu_pkg.sv
design/inst_decoder.sv
design/reg_file.sv
design/alu.sv
design/branch_unit.sv
design/hazard_ctrl.sv
design/cpu_top.sv
dv/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu_top

sources:
  - design/cpu_pkg.sv
  - design/inst_decoder.sv
  - design/reg_file.sv
  - design/alu.sv
  - design/branch_unit.sv
  - design/hazard_ctrl.sv
  - design/cpu_top.sv
  - target: simulation
    files:
      - dv/cpu_tb.sv
